// File: verilog/pmu_pkg.sv
// Sizes, register map, config bits, vector types, bus and control structs, self-test modes
package pmu_pkg;

    // ------------------------------------------------
    // Sizes
    // ------------------------------------------------
    localparam int N_COUNTERS      = 8;
    localparam int N_SOC_EV        = 32;
    localparam int REG_WIDTH       = 32;
    localparam int XBAR_SEL_BITS   = $clog2(N_SOC_EV);
    localparam int CNT_IDX_BITS    = $clog2(N_COUNTERS);
    localparam int ADDR_BITS       = 4;
    localparam int SELFTEST_BITS   = 2;
    // Sum of eight full counters needs three extra carry bits
    localparam int QUOTA_SUM_WIDTH = REG_WIDTH + CNT_IDX_BITS;

    // Plain vectors
    typedef logic [REG_WIDTH-1:0]       reg_data_t;
    typedef logic [ADDR_BITS-1:0]       reg_addr_t;
    typedef logic [REG_WIDTH-1:0]       counter_t;
    typedef logic [N_COUNTERS-1:0]      counter_mask_t;
    typedef logic [N_SOC_EV-1:0]        soc_events_t;
    typedef logic [XBAR_SEL_BITS-1:0]   xbar_sel_t;
    typedef logic [QUOTA_SUM_WIDTH-1:0] quota_sum_t;

    // One selector per counter, counter 0 in the low bits
    typedef xbar_sel_t [N_COUNTERS-1:0] xbar_cfg_t;
    typedef counter_t [N_COUNTERS-1:0]  counter_array_t;

    // ------------------------------------------------
    // Register map
    // ------------------------------------------------
    localparam reg_addr_t ADDR_CFG         = 4'd0;
    // Counters sit at 1..8
    localparam reg_addr_t ADDR_CNT_BASE    = 4'd1;
    localparam reg_addr_t ADDR_OVF_MASK    = 4'd9;
    // Read only
    localparam reg_addr_t ADDR_OVF_VECT    = 4'd10;
    localparam reg_addr_t ADDR_QUOTA_MASK  = 4'd11;
    localparam reg_addr_t ADDR_QUOTA_LIMIT = 4'd12;
    localparam reg_addr_t ADDR_XBAR_LO     = 4'd13;
    localparam reg_addr_t ADDR_XBAR_HI     = 4'd14;
    localparam int        N_REGS           = 15;

    // Fields of the config word
    localparam int CFG_EN_BIT            = 0;
    localparam int CFG_SOFTRST_BIT       = 1;
    localparam int CFG_OVF_EN_BIT        = 2;
    localparam int CFG_OVF_SOFTRST_BIT   = 3;
    localparam int CFG_QUOTA_SOFTRST_BIT = 4;
    localparam int CFG_SELFTEST_LSB      = 30;

    // Event override used for bring-up checks
    typedef enum logic [SELFTEST_BITS-1:0] {
        ST_OFF        = 2'd0,
        ST_ALL_ACTIVE = 2'd1,
        ST_ALL_OFF    = 2'd2,
        ST_ONE_ON     = 2'd3
    } selftest_e;

    // ------------------------------------------------
    // Structs
    // ------------------------------------------------
    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        reg_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic      valid;
        reg_data_t rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic          en;
        logic          softrst;
        logic          ovf_en;
        logic          ovf_softrst;
        logic          quota_softrst;
        selftest_e     selftest;
        counter_mask_t ovf_mask;
        counter_mask_t quota_mask;
        counter_t      quota_limit;
    } pmu_ctrl_t;

    typedef struct packed {
        logic                    valid;
        logic [CNT_IDX_BITS-1:0] index;
        counter_t                data;
    } cnt_write_t;

endpackage

// File: verilog/pmu_regs.sv
// Register bank: host write decode, counter write request, read mux, registered read response
`timescale 1ns/1ps

module pmu_regs (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  pmu_pkg::bus_req_t       bus_req_i,
    input  pmu_pkg::counter_array_t counters_i,
    input  pmu_pkg::counter_mask_t  ovf_vect_i,
    output pmu_pkg::pmu_ctrl_t      ctrl_o,
    output pmu_pkg::xbar_cfg_t      xbar_cfg_o,
    output pmu_pkg::cnt_write_t     cnt_wr_o,
    output pmu_pkg::bus_rsp_t       bus_rsp_o
);
    import pmu_pkg::*;

    // Software visible state
    reg_data_t     cfg_q;
    counter_mask_t ovf_mask_q;
    counter_mask_t quota_mask_q;
    counter_t      quota_limit_q;
    reg_data_t     xbar_lo_q;
    reg_data_t     xbar_hi_q;

    // Address decode
    logic          wr_en;
    logic          is_cnt;
    reg_addr_t     cnt_off;
    logic [2*REG_WIDTH-1:0] xbar_words;

    // Read path
    reg_data_t     rdata_d;
    logic          rsp_valid_q;
    reg_data_t     rsp_rdata_q;

    // Offset into the counter window, only meaningful when is_cnt
    assign cnt_off = bus_req_i.addr - ADDR_CNT_BASE;
    assign is_cnt  = (bus_req_i.addr >= ADDR_CNT_BASE) && (cnt_off < N_COUNTERS);
    // Addresses past the map are dropped
    assign wr_en   = bus_req_i.valid && bus_req_i.write && (bus_req_i.addr < N_REGS);

    // ------------------------------------------------
    // Host writes
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
            xbar_lo_q     <= '0;
            xbar_hi_q     <= '0;
        end else if (wr_en) begin
            case (bus_req_i.addr)
                ADDR_CFG:         cfg_q         <= bus_req_i.wdata;
                ADDR_OVF_MASK:    ovf_mask_q    <= bus_req_i.wdata[N_COUNTERS-1:0];
                ADDR_QUOTA_MASK:  quota_mask_q  <= bus_req_i.wdata[N_COUNTERS-1:0];
                ADDR_QUOTA_LIMIT: quota_limit_q <= bus_req_i.wdata;
                ADDR_XBAR_LO:     xbar_lo_q     <= bus_req_i.wdata;
                ADDR_XBAR_HI:     xbar_hi_q     <= bus_req_i.wdata;
                // Counters go through cnt_wr_o, the overflow vector is read only
                default: ;
            endcase
        end
    end

    // Counter writes land in the counter bank on the same edge
    assign cnt_wr_o.valid = bus_req_i.valid && bus_req_i.write && is_cnt;
    assign cnt_wr_o.index = cnt_off[CNT_IDX_BITS-1:0];
    assign cnt_wr_o.data  = bus_req_i.wdata;

    // Selector 6 straddles the two crossbar words
    assign xbar_words = {xbar_hi_q, xbar_lo_q};
    assign xbar_cfg_o = xbar_words[N_COUNTERS*XBAR_SEL_BITS-1:0];

    // Control fields
    assign ctrl_o.en            = cfg_q[CFG_EN_BIT];
    assign ctrl_o.softrst       = cfg_q[CFG_SOFTRST_BIT];
    assign ctrl_o.ovf_en        = cfg_q[CFG_OVF_EN_BIT];
    assign ctrl_o.ovf_softrst   = cfg_q[CFG_OVF_SOFTRST_BIT];
    assign ctrl_o.quota_softrst = cfg_q[CFG_QUOTA_SOFTRST_BIT];
    assign ctrl_o.selftest      = selftest_e'(cfg_q[CFG_SELFTEST_LSB +: SELFTEST_BITS]);
    assign ctrl_o.ovf_mask      = ovf_mask_q;
    assign ctrl_o.quota_mask    = quota_mask_q;
    assign ctrl_o.quota_limit   = quota_limit_q;

    // ------------------------------------------------
    // Read mux and response
    // ------------------------------------------------
    always_comb begin
        rdata_d = '0;
        if (is_cnt) begin
            rdata_d = counters_i[cnt_off[CNT_IDX_BITS-1:0]];
        end else begin
            case (bus_req_i.addr)
                ADDR_CFG:         rdata_d = cfg_q;
                ADDR_OVF_MASK:    rdata_d = reg_data_t'(ovf_mask_q);
                ADDR_OVF_VECT:    rdata_d = reg_data_t'(ovf_vect_i);
                ADDR_QUOTA_MASK:  rdata_d = reg_data_t'(quota_mask_q);
                ADDR_QUOTA_LIMIT: rdata_d = quota_limit_q;
                ADDR_XBAR_LO:     rdata_d = xbar_lo_q;
                ADDR_XBAR_HI:     rdata_d = xbar_hi_q;
                default:          rdata_d = '0;
            endcase
        end
    end

    // Valid for exactly one cycle after the read edge
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rsp_valid_q <= 1'b0;
            rsp_rdata_q <= '0;
        end else begin
            rsp_valid_q <= bus_req_i.valid && !bus_req_i.write;
            rsp_rdata_q <= rdata_d;
        end
    end

    assign bus_rsp_o.valid = rsp_valid_q;
    assign bus_rsp_o.rdata = rsp_rdata_q;

endmodule

// File: verilog/pmu_event_select.sv
// Event crossbar with self-test override and registered output
`timescale 1ns/1ps

module pmu_event_select (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pmu_pkg::soc_events_t   events_i,
    input  pmu_pkg::xbar_cfg_t     xbar_cfg_i,
    input  pmu_pkg::selftest_e     selftest_i,
    output pmu_pkg::counter_mask_t sel_events_o
);
    import pmu_pkg::*;

    counter_mask_t routed;
    counter_mask_t sel_d;
    counter_mask_t sel_q;

    // ------------------------------------------------
    // Crossbar
    // ------------------------------------------------
    // One 32:1 mux per counter
    always_comb begin
        for (int i = 0; i < N_COUNTERS; i++) begin
            routed[i] = events_i[xbar_cfg_i[i]];
        end
    end

    // Self-test replaces the routed events
    always_comb begin
        case (selftest_i)
            ST_ALL_ACTIVE: sel_d = '1;
            ST_ALL_OFF:    sel_d = '0;
            // Only counter 0 sees an event
            ST_ONE_ON:     sel_d = counter_mask_t'(1);
            default:       sel_d = routed;
        endcase
    end

    // ------------------------------------------------
    // Output stage
    // ------------------------------------------------
    // Cuts the path from the SoC lines into the counter adders
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sel_q <= '0;
        end else begin
            sel_q <= sel_d;
        end
    end

    assign sel_events_o = sel_q;

endmodule

// File: verilog/pmu_counters.sv
// Counter bank: enable, soft reset, host writes and wrap pulses
`timescale 1ns/1ps

module pmu_counters (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    en_i,
    input  logic                    softrst_i,
    input  pmu_pkg::cnt_write_t     cnt_wr_i,
    input  pmu_pkg::counter_mask_t  sel_events_i,
    output pmu_pkg::counter_array_t counters_o,
    output pmu_pkg::counter_mask_t  wrap_o
);
    import pmu_pkg::*;

    counter_array_t cnt_q;
    counter_array_t cnt_d;
    counter_mask_t  wrap_q;
    counter_mask_t  wrap_d;

    // ------------------------------------------------
    // Next state
    // ------------------------------------------------
    always_comb begin
        cnt_d  = cnt_q;
        wrap_d = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (softrst_i) begin
                // Held clear for as long as the bit stays set
                cnt_d[i] = '0;
            end else if (cnt_wr_i.valid && (cnt_wr_i.index == CNT_IDX_BITS'(i))) begin
                // Host value wins over an event in the same cycle
                cnt_d[i] = cnt_wr_i.data;
            end else if (en_i && sel_events_i[i]) begin
                cnt_d[i]  = cnt_q[i] + counter_t'(1);
                // All ones rolls over to zero
                wrap_d[i] = &cnt_q[i];
            end
        end
    end

    // ------------------------------------------------
    // State
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    // Wrap pulse lasts the one cycle after the rollover edge
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wrap_q <= '0;
        end else begin
            wrap_q <= wrap_d;
        end
    end

    assign counters_o = cnt_q;
    assign wrap_o     = wrap_q;

endmodule

// File: verilog/pmu_interrupts.sv
// Sticky overflow vector, masked overflow interrupt and quota interrupt
`timescale 1ns/1ps

module pmu_interrupts (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  pmu_pkg::pmu_ctrl_t      ctrl_i,
    input  pmu_pkg::counter_array_t counters_i,
    input  pmu_pkg::counter_mask_t  wrap_i,
    output pmu_pkg::counter_mask_t  ovf_vect_o,
    output logic                    intr_overflow_o,
    output logic                    intr_quota_o
);
    import pmu_pkg::*;

    counter_mask_t ovf_vect_q;
    quota_sum_t    quota_sum;
    logic          quota_armed;
    logic          quota_hit;
    logic          quota_q;

    // ------------------------------------------------
    // Overflow
    // ------------------------------------------------
    // Bits collect wrap pulses until software clears them
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_vect_q <= '0;
        end else if (ctrl_i.ovf_softrst) begin
            ovf_vect_q <= '0;
        end else if (ctrl_i.ovf_en) begin
            ovf_vect_q <= ovf_vect_q | wrap_i;
        end
    end

    assign ovf_vect_o = ovf_vect_q;
    // Straight from registers, no extra stage
    assign intr_overflow_o = |(ovf_vect_q & ctrl_i.ovf_mask);

    // ------------------------------------------------
    // Quota
    // ------------------------------------------------
    // Adder tree over the selected counters
    always_comb begin
        quota_sum = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (ctrl_i.quota_mask[i]) begin
                quota_sum = quota_sum + quota_sum_t'(counters_i[i]);
            end
        end
    end

    // A zero limit means no quota is programmed
    assign quota_armed = |ctrl_i.quota_limit;
    assign quota_hit   = quota_armed && (quota_sum >= quota_sum_t'(ctrl_i.quota_limit));

    // Sticky until the quota soft reset
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            quota_q <= 1'b0;
        end else if (ctrl_i.quota_softrst) begin
            quota_q <= 1'b0;
        end else if (quota_hit) begin
            quota_q <= 1'b1;
        end
    end

    assign intr_quota_o = quota_q;

endmodule

// File: verilog/pmu_top.sv
// PMU top level connecting register bank, event select, counter bank and interrupt unit
`timescale 1ns/1ps

module pmu_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  pmu_pkg::bus_req_t     bus_req_i,
    input  pmu_pkg::soc_events_t  events_i,
    output pmu_pkg::bus_rsp_t     bus_rsp_o,
    output logic                  intr_overflow_o,
    output logic                  intr_quota_o
);
    import pmu_pkg::*;

    // Decoded register state
    pmu_ctrl_t      ctrl;
    xbar_cfg_t      xbar_cfg;
    cnt_write_t     cnt_wr;

    // Datapath between the units
    counter_mask_t  sel_events;
    counter_array_t counters;
    counter_mask_t  wrap;
    counter_mask_t  ovf_vect;

    // ------------------------------------------------
    // Input side
    // ------------------------------------------------
    pmu_regs u_regs (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .bus_req_i  (bus_req_i),
        .counters_i (counters),
        .ovf_vect_i (ovf_vect),
        .ctrl_o     (ctrl),
        .xbar_cfg_o (xbar_cfg),
        .cnt_wr_o   (cnt_wr),
        .bus_rsp_o  (bus_rsp_o)
    );

    pmu_event_select u_event_select (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .events_i     (events_i),
        .xbar_cfg_i   (xbar_cfg),
        .selftest_i   (ctrl.selftest),
        .sel_events_o (sel_events)
    );

    // Counting, two edges behind events_i
    pmu_counters u_counters (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .en_i         (ctrl.en),
        .softrst_i    (ctrl.softrst),
        .cnt_wr_i     (cnt_wr),
        .sel_events_i (sel_events),
        .counters_o   (counters),
        .wrap_o       (wrap)
    );

    // ------------------------------------------------
    // Output side
    // ------------------------------------------------
    pmu_interrupts u_interrupts (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .ctrl_i          (ctrl),
        .counters_i      (counters),
        .wrap_i          (wrap),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

endmodule

// File: tests/pmu_asserts.sv
// Bound concurrent checks on the PMU host port and interrupt outputs
`timescale 1ns/1ps

module pmu_asserts (
    input logic                   clk_i,
    input logic                   rstn_i,
    input pmu_pkg::bus_req_t      bus_req_i,
    input pmu_pkg::bus_rsp_t      bus_rsp_i,
    input logic                   intr_overflow_i,
    input logic                   intr_quota_i,
    input pmu_pkg::counter_mask_t ovf_vect_i
);

    // --------------------------------------------------
    // Host port
    // --------------------------------------------------
    // A response only follows a read taken one edge earlier
    rsp_needs_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        bus_rsp_i.valid |-> $past(bus_req_i.valid && !bus_req_i.write))
        else $error("read response without a read request one cycle earlier");

    // Every read gets its response in the next cycle
    read_gets_rsp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (bus_req_i.valid && !bus_req_i.write) |=> bus_rsp_i.valid)
        else $error("read request without a response in the next cycle");

    // --------------------------------------------------
    // Interrupts
    // --------------------------------------------------
    // Both lines quiet right after reset
    irq_low_after_reset: assert property (@(posedge clk_i)
        !rstn_i |=> (!intr_overflow_i && !intr_quota_i))
        else $error("interrupt high in the cycle after reset");

    // Overflow interrupt needs a captured overflow
    ovf_irq_has_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        intr_overflow_i |-> (ovf_vect_i != '0))
        else $error("overflow interrupt with an empty overflow vector");

endmodule

bind pmu_top pmu_asserts u_asserts (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .bus_req_i       (bus_req_i),
    .bus_rsp_i       (bus_rsp_o),
    .intr_overflow_i (intr_overflow_o),
    .intr_quota_i    (intr_quota_o),
    .ovf_vect_i      (ovf_vect)
);

// File: tests/pmu_tb.sv
// Testbench for pmu_top: clock, reset, LFSR stimulus, reference model, checks and summary
`timescale 1ns/1ps

module pmu_tb;
    import pmu_pkg::*;

    // Config bit groups, low five bits of the config word
    localparam logic [4:0] cfg_en         = 5'b00001;
    localparam logic [4:0] cfg_srst       = 5'b00010;
    localparam logic [4:0] cfg_ovf_en     = 5'b00100;
    localparam logic [4:0] cfg_ovf_srst   = 5'b01000;
    localparam logic [4:0] cfg_quota_srst = 5'b10000;
    localparam reg_addr_t  cls_addrs [6]  = '{ADDR_OVF_MASK, ADDR_OVF_VECT, ADDR_QUOTA_MASK,
                                             ADDR_QUOTA_LIMIT, ADDR_XBAR_LO, ADDR_XBAR_HI};
    localparam selftest_e  st_modes [3]   = '{ST_ALL_ACTIVE, ST_ALL_OFF, ST_ONE_ON};

    logic          clk;
    logic          rstn;
    bus_req_t      bus_req;
    soc_events_t   events;
    bus_rsp_t      bus_rsp;
    logic          intr_overflow;
    logic          intr_quota;
    int unsigned   val_errors;
    int unsigned   other_errors;
    logic [31:0]   lfsr_state;

    // Reference model state
    reg_data_t     m_cfg;
    counter_mask_t m_ovf_mask;
    counter_mask_t m_quota_mask;
    counter_t      m_quota_limit;
    reg_data_t     m_xbar_lo;
    reg_data_t     m_xbar_hi;
    counter_mask_t m_sel;
    counter_t      m_cnt [N_COUNTERS];
    counter_mask_t m_wrap;
    counter_mask_t m_ovf_vect;
    logic          m_quota;
    logic          m_rsp_valid;
    reg_data_t     m_rsp_rdata;

    pmu_top dut0 (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .bus_req_i       (bus_req),
        .events_i        (events),
        .bus_rsp_o       (bus_rsp),
        .intr_overflow_o (intr_overflow),
        .intr_quota_o    (intr_quota)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // Random source
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v[i] = lfsr_state[0];
        end
        return v;
    endfunction

    function automatic reg_data_t cfg_word(input selftest_e st, input logic [4:0] bits);
        return {st, 25'b0, bits};
    endfunction

    function automatic reg_addr_t cnt_addr(input int i);
        return ADDR_CNT_BASE + reg_addr_t'(i);
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    task automatic model_reset();
        m_cfg = '0;
        m_ovf_mask = '0;
        m_quota_mask = '0;
        m_quota_limit = '0;
        m_xbar_lo = '0;
        m_xbar_hi = '0;
        m_sel = '0;
        m_wrap = '0;
        m_ovf_vect = '0;
        m_quota = 1'b0;
        m_rsp_valid = 1'b0;
        m_rsp_rdata = '0;
        for (int i = 0; i < N_COUNTERS; i++) m_cnt[i] = '0;
    endtask

    function automatic reg_data_t model_read(input reg_addr_t a);
        if (a >= ADDR_CNT_BASE && a < ADDR_OVF_MASK) return m_cnt[int'(a - ADDR_CNT_BASE)];
        case (a)
            ADDR_CFG:         return m_cfg;
            ADDR_OVF_MASK:    return {24'b0, m_ovf_mask};
            ADDR_OVF_VECT:    return {24'b0, m_ovf_vect};
            ADDR_QUOTA_MASK:  return {24'b0, m_quota_mask};
            ADDR_QUOTA_LIMIT: return m_quota_limit;
            ADDR_XBAR_LO:     return m_xbar_lo;
            ADDR_XBAR_HI:     return m_xbar_hi;
            default:          return '0;
        endcase
    endfunction

    // Source line of counter i, five bits per counter across both words
    function automatic int sel_index(input int i);
        logic [63:0] w;
        w = {m_xbar_hi, m_xbar_lo};
        return int'(w[XBAR_SEL_BITS*i +: XBAR_SEL_BITS]);
    endfunction

    // Applies one clock edge, every next value taken from the old state
    task automatic model_edge();
        counter_mask_t sel_d;
        counter_mask_t wrap_d;
        counter_t      cnt_d [N_COUNTERS];
        logic [34:0]   sum;
        logic          wr;
        int            idx;
        m_rsp_valid = bus_req.valid && !bus_req.write;
        m_rsp_rdata = model_read(bus_req.addr);
        for (int i = 0; i < N_COUNTERS; i++) sel_d[i] = events[sel_index(i)];
        case (selftest_e'(m_cfg[CFG_SELFTEST_LSB +: 2]))
            ST_ALL_ACTIVE: sel_d = '1;
            ST_ALL_OFF:    sel_d = '0;
            ST_ONE_ON:     sel_d = 8'h01;
            default: ;
        endcase
        wr = bus_req.valid && bus_req.write && bus_req.addr >= ADDR_CNT_BASE
            && bus_req.addr < ADDR_OVF_MASK;
        idx = int'(bus_req.addr - ADDR_CNT_BASE);
        wrap_d = '0;
        sum = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (m_quota_mask[i]) sum = sum + 35'(m_cnt[i]);
            cnt_d[i] = m_cnt[i];
            if (m_cfg[CFG_SOFTRST_BIT]) begin
                cnt_d[i] = '0;
            end else if (wr && idx == i) begin
                cnt_d[i] = bus_req.wdata;
            end else if (m_cfg[CFG_EN_BIT] && m_sel[i]) begin
                cnt_d[i] = m_cnt[i] + 32'd1;
                wrap_d[i] = (m_cnt[i] == 32'hFFFF_FFFF);
            end
        end
        // Vector and quota flag see the wrap pulse and counts from before the edge
        if (m_cfg[CFG_OVF_SOFTRST_BIT]) m_ovf_vect = '0;
        else if (m_cfg[CFG_OVF_EN_BIT]) m_ovf_vect = m_ovf_vect | m_wrap;
        if (m_cfg[CFG_QUOTA_SOFTRST_BIT]) m_quota = 1'b0;
        else if (m_quota_limit != 0 && sum >= 35'(m_quota_limit)) m_quota = 1'b1;
        m_cnt = cnt_d;
        m_wrap = wrap_d;
        m_sel = sel_d;
        if (bus_req.valid && bus_req.write) begin
            case (bus_req.addr)
                ADDR_CFG:         m_cfg = bus_req.wdata;
                ADDR_OVF_MASK:    m_ovf_mask = bus_req.wdata[7:0];
                ADDR_QUOTA_MASK:  m_quota_mask = bus_req.wdata[7:0];
                ADDR_QUOTA_LIMIT: m_quota_limit = bus_req.wdata;
                ADDR_XBAR_LO:     m_xbar_lo = bus_req.wdata;
                ADDR_XBAR_HI:     m_xbar_hi = bus_req.wdata;
                default: ;
            endcase
        end
    endtask

    // --------------------------------------------------
    // Checks and bus helpers
    // --------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expv);
        val_errors++;
        $display("ERR %0t %s got %h expected %h", $time, name, got, expv);
    endtask

    task automatic finish_run();
        $display("Errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Outputs compared with the model every cycle
    task automatic check_outputs();
        if (bus_rsp.valid !== m_rsp_valid)
            report_mismatch("bus_rsp_o.valid", 32'(bus_rsp.valid), 32'(m_rsp_valid));
        if (m_rsp_valid && bus_rsp.rdata !== m_rsp_rdata)
            report_mismatch("bus_rsp_o.rdata", bus_rsp.rdata, m_rsp_rdata);
        if (intr_overflow !== |(m_ovf_vect & m_ovf_mask))
            report_mismatch("intr_overflow_o", 32'(intr_overflow),
                            32'(|(m_ovf_vect & m_ovf_mask)));
        if (intr_quota !== m_quota)
            report_mismatch("intr_quota_o", 32'(intr_quota), 32'(m_quota));
    endtask

    // Edge, model update, then new inputs 10 ns later
    task automatic tick();
        @(posedge clk);
        model_edge();
        #10;
        check_outputs();
    endtask

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        bus_req = '{valid: 1'b1, write: 1'b1, addr: a, wdata: d};
        tick();
        bus_req = '0;
    endtask

    task automatic read_reg(input reg_addr_t a, output reg_data_t d);
        int waited;
        bus_req = '{valid: 1'b1, write: 1'b0, addr: a, wdata: '0};
        tick();
        bus_req = '0;
        waited = 0;
        while (!bus_rsp.valid && waited < 8) begin
            tick();
            waited++;
        end
        if (!bus_rsp.valid) begin
            other_errors++;
            $display("No read response for register %0d within 8 cycles", a);
        end else begin
            d = bus_rsp.rdata;
        end
    endtask

    task automatic clear_counters();
        write_reg(ADDR_CFG, cfg_word(ST_OFF, cfg_srst));
        write_reg(ADDR_CFG, '0);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        reg_data_t rd;
        reg_data_t wd;
        reg_data_t expv;
        reg_addr_t a;
        int        waited;
        rstn = 1'b0;
        bus_req = '0;
        events = '0;
        val_errors = 0;
        other_errors = 0;
        lfsr_state = 32'h931e_8a45;
        model_reset();
        repeat (5) @(posedge clk);
        #10;
        rstn = 1'b1;

        // Register readback, vector ignores writes, unmapped reads zero
        for (int k = 0; k < 18; k++) begin
            a = cls_addrs[k % 6];
            wd = rand_bits(32);
            write_reg(a, wd);
            if (a == ADDR_OVF_MASK || a == ADDR_QUOTA_MASK) expv = wd & 32'hFF;
            else if (a == ADDR_OVF_VECT) expv = {24'b0, m_ovf_vect};
            else expv = wd;
            read_reg(a, rd);
            if (rd !== expv) report_mismatch("bus_rsp_o.rdata readback", rd, expv);
        end
        write_reg(4'd15, rand_bits(32));
        read_reg(4'd15, rd);
        if (rd !== 32'h0) report_mismatch("bus_rsp_o.rdata unmapped", rd, 32'h0);

        // Crossbar counting of random events
        clear_counters();
        write_reg(ADDR_XBAR_LO, rand_bits(32));
        write_reg(ADDR_XBAR_HI, rand_bits(32));
        write_reg(ADDR_CFG, cfg_word(ST_OFF, cfg_en));
        for (int k = 0; k < 200; k++) begin
            events = rand_bits(32);
            tick();
        end
        events = '0;
        write_reg(ADDR_CFG, '0);
        for (int i = 0; i < N_COUNTERS; i++) begin
            read_reg(cnt_addr(i), rd);
            if (rd !== m_cnt[i]) report_mismatch("bus_rsp_o.rdata crossbar count", rd, m_cnt[i]);
        end

        // Self-test modes, 20 counted cycles each
        for (int m = 0; m < 3; m++) begin
            clear_counters();
            write_reg(ADDR_CFG, cfg_word(st_modes[m], cfg_en));
            for (int k = 0; k < 20; k++) begin
                events = rand_bits(32);
                tick();
            end
            events = '0;
            write_reg(ADDR_CFG, '0);
            for (int i = 0; i < N_COUNTERS; i++) begin
                expv = (st_modes[m] == ST_ALL_ACTIVE || (st_modes[m] == ST_ONE_ON && i == 0))
                    ? 32'd20 : 32'd0;
                read_reg(cnt_addr(i), rd);
                if (rd !== expv) report_mismatch("bus_rsp_o.rdata self-test count", rd, expv);
            end
        end

        // Wrap from near all ones into the overflow vector
        write_reg(ADDR_OVF_MASK, rand_bits(8) | 32'h1);
        for (int i = 0; i < N_COUNTERS; i++) write_reg(cnt_addr(i), 32'hFFFF_FFFF - rand_bits(2));
        write_reg(ADDR_CFG, cfg_word(ST_ALL_ACTIVE, cfg_en | cfg_ovf_en));
        waited = 0;
        while (!intr_overflow && waited < 20) begin
            tick();
            waited++;
        end
        if (!intr_overflow) begin
            other_errors++;
            $display("intr_overflow_o did not rise within 20 cycles");
        end
        repeat (8) tick();
        write_reg(ADDR_CFG, '0);
        read_reg(ADDR_OVF_VECT, rd);
        if (rd !== 32'hFF) report_mismatch("bus_rsp_o.rdata overflow vector", rd, 32'hFF);
        if (intr_overflow !== 1'b1) report_mismatch("intr_overflow_o", 32'(intr_overflow), 1);
        write_reg(ADDR_CFG, cfg_word(ST_OFF, cfg_ovf_srst));
        write_reg(ADDR_CFG, '0);
        read_reg(ADDR_OVF_VECT, rd);
        if (rd !== 32'h0) report_mismatch("bus_rsp_o.rdata overflow vector", rd, 32'h0);
        if (intr_overflow !== 1'b0) report_mismatch("intr_overflow_o", 32'(intr_overflow), 0);

        // Quota on the masked sum
        write_reg(ADDR_CFG, cfg_word(ST_OFF, cfg_srst | cfg_quota_srst));
        write_reg(ADDR_QUOTA_MASK, rand_bits(8) | 32'h1);
        write_reg(ADDR_QUOTA_LIMIT, 32'd16 + rand_bits(6));
        write_reg(ADDR_CFG, cfg_word(ST_ALL_ACTIVE, cfg_en));
        waited = 0;
        while (!intr_quota && waited < 200) begin
            tick();
            waited++;
        end
        if (!intr_quota) begin
            other_errors++;
            $display("intr_quota_o did not rise within 200 cycles");
        end
        write_reg(ADDR_CFG, '0);
        repeat (5) tick();
        if (intr_quota !== 1'b1) report_mismatch("intr_quota_o", 32'(intr_quota), 1);
        write_reg(ADDR_CFG, cfg_word(ST_OFF, cfg_srst | cfg_quota_srst));
        write_reg(ADDR_CFG, '0);
        tick();
        if (intr_quota !== 1'b0) report_mismatch("intr_quota_o", 32'(intr_quota), 0);

        // Counter soft reset after some counting
        write_reg(ADDR_CFG, cfg_word(ST_ALL_ACTIVE, cfg_en));
        repeat (10) tick();
        clear_counters();
        for (int i = 0; i < N_COUNTERS; i++) begin
            read_reg(cnt_addr(i), rd);
            if (rd !== 32'h0) report_mismatch("bus_rsp_o.rdata after softrst", rd, 32'h0);
        end
        finish_run();
    end

endmodule

// File: pmu_lite.f
verilog/pmu_pkg.sv
verilog/pmu_regs.sv
verilog/pmu_event_select.sv
verilog/pmu_counters.sv
verilog/pmu_interrupts.sv
verilog/pmu_top.sv
tests/pmu_asserts.sv
tests/pmu_tb.sv

// File: Makefile
# Verilator build and run of the pmu_lite testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f pmu_lite.f \
		--top-module pmu_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vpmu_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
